// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary -j 0
TOP      = pcs_rx_tb
FILELIST = pcs_rx.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: simulate clean

simulate:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== logic/block_lock_fsm.sv ====
// lock judged on sync headers only; no bit slip, so input blocks must already be framed
`default_nettype none
`timescale 1ns/1ns

module block_lock_fsm
#(
    parameter int LOCK_COUNT    = 64,
    parameter int UNLOCK_WINDOW = 64,
    parameter int UNLOCK_LIMIT  = 16
)
(
    input  wire                   i_clock,
    input  wire                   i_reset,
    input  wire pcs_rx_pkg::rx_block_t i_block,
    output logic                  o_block_lock,
    output logic                  o_hdr_err
);

    localparam int NB_GOOD = $clog2(LOCK_COUNT + 1);
    localparam int NB_WIN  = $clog2(UNLOCK_WINDOW + 1);
    localparam int NB_INV  = $clog2(UNLOCK_LIMIT + 1);

    pcs_rx_pkg::lock_state_t state;
    logic [NB_GOOD-1:0]      good_count;
    logic [NB_WIN-1:0]       win_count;
    logic [NB_INV-1:0]       inv_count;
    logic                    sh_valid;

    // 01 and 10 are the only legal headers
    assign sh_valid     = i_block.header[1] ^ i_block.header[0];
    assign o_hdr_err    = i_block.valid & ~sh_valid;
    assign o_block_lock = (state == pcs_rx_pkg::LOCK_LOCKED);

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            state      <= pcs_rx_pkg::LOCK_HUNT;
            good_count <= '0;
            win_count  <= '0;
            inv_count  <= '0;
        end
        else if (i_block.valid)
        begin
            case (state)
                pcs_rx_pkg::LOCK_HUNT:
                begin
                    // need an unbroken run of good headers
                    if (!sh_valid)
                    begin
                        good_count <= '0;
                    end
                    else if (good_count == NB_GOOD'(LOCK_COUNT - 1))
                    begin
                        state      <= pcs_rx_pkg::LOCK_LOCKED;
                        good_count <= '0;
                        win_count  <= '0;
                        inv_count  <= '0;
                    end
                    else
                    begin
                        good_count <= good_count + NB_GOOD'(1);
                    end
                end
                pcs_rx_pkg::LOCK_LOCKED:
                begin
                    if (!sh_valid && inv_count == NB_INV'(UNLOCK_LIMIT - 1))
                    begin
                        state     <= pcs_rx_pkg::LOCK_HUNT;
                        win_count <= '0;
                        inv_count <= '0;
                    end
                    else if (win_count == NB_WIN'(UNLOCK_WINDOW - 1))
                    begin
                        // window closed below the limit, start over
                        win_count <= '0;
                        inv_count <= '0;
                    end
                    else
                    begin
                        win_count <= win_count + NB_WIN'(1);
                        if (!sh_valid)
                        begin
                            inv_count <= inv_count + NB_INV'(1);
                        end
                    end
                end
                default:
                begin
                    state <= pcs_rx_pkg::LOCK_HUNT;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== logic/hi_ber_monitor.sv ====
// hi_ber window counts valid blocks only; threshold and window length fixed per build
`default_nettype none
`timescale 1ns/1ns

module hi_ber_monitor
#(
    parameter int BER_WINDOW   = 1024,
    parameter int HI_BER_COUNT = 97
)
(
    input  wire                   i_clock,
    input  wire                   i_reset,
    input  wire pcs_rx_pkg::rx_block_t i_block,
    output logic                  o_hi_ber
);

    localparam int NB_WIN = $clog2(BER_WINDOW + 1);
    localparam int NB_ERR = $clog2(HI_BER_COUNT + 1);

    logic [NB_WIN-1:0] win_count;
    logic [NB_ERR-1:0] err_count;
    logic [NB_ERR-1:0] err_next;
    logic              bad_sh;
    logic              at_limit;
    logic              win_end;

    assign bad_sh   = ~(i_block.header[1] ^ i_block.header[0]);
    assign at_limit = (err_count == NB_ERR'(HI_BER_COUNT));
    assign win_end  = (win_count == NB_WIN'(BER_WINDOW - 1));

    // count saturates at the threshold
    always_comb
    begin
        err_next = err_count;
        if (i_block.valid && bad_sh && !at_limit)
        begin
            err_next = err_count + NB_ERR'(1);
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            win_count <= '0;
            err_count <= '0;
            o_hi_ber  <= 1'b0;
        end
        else if (i_block.valid && win_end)
        begin
            // window boundary decides whether hi_ber stays up
            win_count <= '0;
            err_count <= '0;
            o_hi_ber  <= (err_next == NB_ERR'(HI_BER_COUNT));
        end
        else
        begin
            if (i_block.valid)
            begin
                win_count <= win_count + NB_WIN'(1);
            end
            err_count <= err_next;
            if (at_limit)
            begin
                o_hi_ber <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/lane_descrambler.sv ====
// x^58+x^39+1 self-synchronous descrambler, payload LSB first; header is never scrambled
`default_nettype none
`timescale 1ns/1ns

module lane_descrambler
(
    input  wire                   i_clock,
    input  wire                   i_reset,
    input  wire pcs_rx_pkg::rx_block_t i_block,
    input  wire                   i_block_lock,
    input  wire                   i_enable,
    output pcs_rx_pkg::rx_block_t o_block
);

    localparam int NB_STATE = 58;
    localparam int TAP      = 39;
    localparam int NB_EXT   = pcs_rx_pkg::NB_PAYLOAD + NB_STATE;

    logic [NB_STATE-1:0]               scr_state;
    logic [NB_EXT-1:0]                 ext;
    logic [pcs_rx_pkg::NB_PAYLOAD-1:0] descrambled;
    logic                              out_valid;
    logic [pcs_rx_pkg::NB_SH-1:0]      out_header;
    logic [pcs_rx_pkg::NB_PAYLOAD-1:0] out_payload;

    // oldest received bit at ext[0], bit i of payload at ext[NB_STATE+i]
    assign ext = {i_block.payload, scr_state};

    // out[i] = s[i] ^ s[i-39] ^ s[i-58]
    assign descrambled = i_block.payload
                       ^ ext[NB_STATE-TAP +: pcs_rx_pkg::NB_PAYLOAD]
                       ^ ext[0 +: pcs_rx_pkg::NB_PAYLOAD];

    // state follows the line even in bypass so re-enabling is seamless
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            scr_state <= '0;
        end
        else if (i_block.valid)
        begin
            scr_state <= ext[NB_EXT-1 -: NB_STATE];
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            out_valid <= 1'b0;
        end
        else
        begin
            out_valid <= i_block.valid & i_block_lock;
        end
    end

    always_ff @(posedge i_clock)
    begin
        out_header  <= i_block.header;
        out_payload <= i_enable ? descrambled : i_block.payload;
    end

    always_comb
    begin
        o_block.valid   = out_valid;
        o_block.header  = out_header;
        o_block.payload = out_payload;
    end

endmodule

`default_nettype wire

// ==== logic/pcs_rx_pkg.sv ====
// shared widths and types; rx_block_t assumes blocks framed on 66-bit boundaries, N_LANES <= 32
`default_nettype none

package pcs_rx_pkg;

    localparam int NB_BLOCK     = 66;
    localparam int NB_PAYLOAD   = 64;
    localparam int NB_SH        = 2;
    localparam int NB_ERR_COUNT = 16;
    localparam int NB_APB_ADDR  = 8;
    localparam int NB_APB_DATA  = 32;

    // one lane's coded block, header 01 or 10 is valid
    typedef struct packed {
        logic                  valid;
        logic [NB_SH-1:0]      header;
        logic [NB_PAYLOAD-1:0] payload;
    } rx_block_t;

    typedef struct packed {
        logic block_lock;
        logic hdr_err;
        logic hi_ber;
    } lane_status_t;

    typedef struct packed {
        logic                   psel;
        logic                   penable;
        logic                   pwrite;
        logic [NB_APB_ADDR-1:0] paddr;
        logic [NB_APB_DATA-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [NB_APB_DATA-1:0] prdata;
        logic                   pready;
        logic                   pslverr;
    } apb_rsp_t;

    typedef enum logic {
        LOCK_HUNT,
        LOCK_LOCKED
    } lock_state_t;

    // error counter of lane n sits at REG_ERR_BASE + 4n
    typedef enum logic [NB_APB_ADDR-1:0] {
        REG_LOCK     = 8'h00,
        REG_HI_BER   = 8'h04,
        REG_CTRL     = 8'h08,
        REG_ERR_BASE = 8'h10
    } reg_addr_t;

endpackage

`default_nettype wire

// ==== logic/pcs_rx_top.sv ====
// all lanes share one valid; blocks arrive framed, no back-pressure, N_LANES at most 32
`default_nettype none
`timescale 1ns/1ns

module pcs_rx_top
#(
    parameter int N_LANES       = 4,
    parameter int LOCK_COUNT    = 64,
    parameter int UNLOCK_WINDOW = 64,
    parameter int UNLOCK_LIMIT  = 16,
    parameter int BER_WINDOW    = 1024,
    parameter int HI_BER_COUNT  = 97
)
(
    input  wire                                      i_clock,
    input  wire                                      i_reset,
    input  wire pcs_rx_pkg::rx_block_t [N_LANES-1:0] i_rx_blocks,
    output wire pcs_rx_pkg::rx_block_t [N_LANES-1:0] o_rx_blocks,
    input  wire pcs_rx_pkg::apb_req_t                i_apb,
    output wire pcs_rx_pkg::apb_rsp_t                o_apb
);

    wire pcs_rx_pkg::lane_status_t [N_LANES-1:0] lane_status;
    wire                                         descramble_enable;

    // one independent receive path per lane
    for (genvar g = 0; g < N_LANES; g++)
    begin : g_lane
        block_lock_fsm
        #(
            .LOCK_COUNT    (LOCK_COUNT),
            .UNLOCK_WINDOW (UNLOCK_WINDOW),
            .UNLOCK_LIMIT  (UNLOCK_LIMIT)
        )
        u_block_lock
        (
            .i_clock      (i_clock),
            .i_reset      (i_reset),
            .i_block      (i_rx_blocks[g]),
            .o_block_lock (lane_status[g].block_lock),
            .o_hdr_err    (lane_status[g].hdr_err)
        );

        hi_ber_monitor
        #(
            .BER_WINDOW   (BER_WINDOW),
            .HI_BER_COUNT (HI_BER_COUNT)
        )
        u_hi_ber
        (
            .i_clock  (i_clock),
            .i_reset  (i_reset),
            .i_block  (i_rx_blocks[g]),
            .o_hi_ber (lane_status[g].hi_ber)
        );

        lane_descrambler
        u_descrambler
        (
            .i_clock      (i_clock),
            .i_reset      (i_reset),
            .i_block      (i_rx_blocks[g]),
            .i_block_lock (lane_status[g].block_lock),
            .i_enable     (descramble_enable),
            .o_block      (o_rx_blocks[g])
        );
    end

    status_regs_apb
    #(
        .N_LANES (N_LANES)
    )
    u_status_regs
    (
        .i_clock             (i_clock),
        .i_reset             (i_reset),
        .i_apb               (i_apb),
        .o_apb               (o_apb),
        .i_lane_status       (lane_status),
        .o_descramble_enable (descramble_enable)
    );

endmodule

`default_nettype wire

// ==== logic/status_regs_apb.sv ====
// zero-wait-state APB slave; only REG_CTRL is writable, N_LANES must not exceed 32
`default_nettype none
`timescale 1ns/1ns

module status_regs_apb
#(
    parameter int N_LANES = 4
)
(
    input  wire                                         i_clock,
    input  wire                                         i_reset,
    input  wire pcs_rx_pkg::apb_req_t                   i_apb,
    output pcs_rx_pkg::apb_rsp_t                        o_apb,
    input  wire pcs_rx_pkg::lane_status_t [N_LANES-1:0] i_lane_status,
    output logic                                        o_descramble_enable
);

    localparam int NB_ERR  = pcs_rx_pkg::NB_ERR_COUNT;
    localparam int NB_ADDR = pcs_rx_pkg::NB_APB_ADDR;

    logic                               access;
    logic                               rd_access;
    logic                               ctrl_wr;
    logic                               hi_ber_rd;
    logic                               addr_hit;
    logic [N_LANES-1:0]                 lock_live;
    logic [N_LANES-1:0]                 hi_ber_live;
    logic [N_LANES-1:0]                 hdr_err_live;
    logic [N_LANES-1:0]                 hi_ber_sticky;
    logic [N_LANES-1:0]                 err_sel;
    logic [NB_ERR-1:0]                  err_count [N_LANES];
    logic [pcs_rx_pkg::NB_APB_DATA-1:0] rd_data;

    assign access    = i_apb.psel & i_apb.penable;
    assign rd_access = access & ~i_apb.pwrite;
    assign ctrl_wr   = access & i_apb.pwrite & (i_apb.paddr == pcs_rx_pkg::REG_CTRL);
    assign hi_ber_rd = rd_access & (i_apb.paddr == pcs_rx_pkg::REG_HI_BER);

    always_comb
    begin
        for (int n = 0; n < N_LANES; n++)
        begin
            lock_live[n]    = i_lane_status[n].block_lock;
            hi_ber_live[n]  = i_lane_status[n].hi_ber;
            hdr_err_live[n] = i_lane_status[n].hdr_err;
            err_sel[n]      = (i_apb.paddr == NB_ADDR'(pcs_rx_pkg::REG_ERR_BASE + 4 * n));
        end
    end

    // read mux and address decode
    always_comb
    begin
        rd_data  = '0;
        addr_hit = 1'b1;
        case (i_apb.paddr)
            pcs_rx_pkg::REG_LOCK:   rd_data[N_LANES-1:0] = lock_live;
            pcs_rx_pkg::REG_HI_BER: rd_data[N_LANES-1:0] = hi_ber_sticky;
            pcs_rx_pkg::REG_CTRL:   rd_data[0] = o_descramble_enable;
            default:
            begin
                addr_hit = |err_sel;
                for (int n = 0; n < N_LANES; n++)
                begin
                    if (err_sel[n])
                    begin
                        rd_data[NB_ERR-1:0] = err_count[n];
                    end
                end
            end
        endcase
    end

    always_comb
    begin
        o_apb.prdata  = rd_data;
        o_apb.pready  = 1'b1;
        o_apb.pslverr = access & (~addr_hit | (i_apb.pwrite & ~ctrl_wr));
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            o_descramble_enable <= 1'b1;
        end
        else if (ctrl_wr)
        begin
            o_descramble_enable <= i_apb.pwdata[0];
        end
    end

    // sticky until read, then reloads with the live level
    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            hi_ber_sticky <= '0;
        end
        else if (hi_ber_rd)
        begin
            hi_ber_sticky <= hi_ber_live;
        end
        else
        begin
            hi_ber_sticky <= hi_ber_sticky | hi_ber_live;
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            for (int n = 0; n < N_LANES; n++)
            begin
                err_count[n] <= '0;
            end
        end
        else
        begin
            for (int n = 0; n < N_LANES; n++)
            begin
                // a read keeps only an error from the same cycle
                if (rd_access && err_sel[n])
                begin
                    err_count[n] <= NB_ERR'(hdr_err_live[n]);
                end
                else if (hdr_err_live[n] && !(&err_count[n]))
                begin
                    err_count[n] <= err_count[n] + NB_ERR'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== pcs_rx.f ====
logic/pcs_rx_pkg.sv
logic/block_lock_fsm.sv
logic/hi_ber_monitor.sv
logic/lane_descrambler.sv
logic/status_regs_apb.sv
logic/pcs_rx_top.sv
sim/pcs_rx_tb.sv

// ==== sim/pcs_rx_tb.sv ====
// lane numbers in the tests assume N_LANES of 4; the run stops at the first mismatch
`default_nettype none
`timescale 1ns/1ns

module pcs_rx_tb;

    localparam int N_LANES       = 4;
    localparam int LOCK_COUNT    = 64;
    localparam int UNLOCK_WINDOW = 64;
    localparam int UNLOCK_LIMIT  = 16;
    localparam int BER_WINDOW    = 1024;
    localparam int HI_BER_COUNT  = 97;
    localparam int NB_PAYLOAD    = pcs_rx_pkg::NB_PAYLOAD;
    localparam int NB_SH         = pcs_rx_pkg::NB_SH;
    localparam int NB_ADDR       = pcs_rx_pkg::NB_APB_ADDR;
    localparam int NB_DATA       = pcs_rx_pkg::NB_APB_DATA;
    localparam int APB_TIMEOUT   = 16;
    localparam logic [N_LANES-1:0] ALL_LANES = '1;

    logic                                     i_clock;
    logic                                     i_reset;
    pcs_rx_pkg::rx_block_t [N_LANES-1:0]      rx_in;
    pcs_rx_pkg::rx_block_t [N_LANES-1:0]      rx_out;
    pcs_rx_pkg::apb_req_t                     apb_req;
    pcs_rx_pkg::apb_rsp_t                     apb_rsp;

    // values for the next clock edge and the expected output one cycle later
    pcs_rx_pkg::rx_block_t [N_LANES-1:0]      next_rx;
    pcs_rx_pkg::apb_req_t                     next_apb;
    pcs_rx_pkg::rx_block_t                    next_exp [N_LANES];
    pcs_rx_pkg::rx_block_t                    pend_exp [N_LANES];
    logic [N_LANES-1:0]                       next_chk;
    logic [N_LANES-1:0]                       pend_chk;

    // transmit side scrambler, st[k] is the bit sent k+1 positions ago
    logic [57:0]                              tx_state [N_LANES];
    logic [31:0]                              rng_state;
    logic                                     descramble_on;
    int                                       total_blocks;

    pcs_rx_top
    #(
        .N_LANES       (N_LANES),
        .LOCK_COUNT    (LOCK_COUNT),
        .UNLOCK_WINDOW (UNLOCK_WINDOW),
        .UNLOCK_LIMIT  (UNLOCK_LIMIT),
        .BER_WINDOW    (BER_WINDOW),
        .HI_BER_COUNT  (HI_BER_COUNT)
    )
    dut0
    (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_rx_blocks (rx_in),
        .o_rx_blocks (rx_out),
        .i_apb       (apb_req),
        .o_apb       (apb_rsp)
    );

    initial
    begin
        i_clock = 1'b0;
        forever #50 i_clock = ~i_clock;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("TB FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [NB_DATA-1:0] lane_word(input logic [N_LANES-1:0] bits);
        logic [NB_DATA-1:0] w;
        w = '0;
        w[N_LANES-1:0] = bits;
        return w;
    endfunction

    // error counter of lane n lives at 0x10 + 4n
    function automatic logic [NB_ADDR-1:0] err_addr(input int lane);
        return NB_ADDR'(8'h10 + 4 * lane);
    endfunction

    // serial x^58+x^39+1 scrambler, payload bit 0 goes first
    task automatic scramble_payload(input int lane, input logic [NB_PAYLOAD-1:0] plain,
                                    output logic [NB_PAYLOAD-1:0] scr);
        logic [57:0] st;
        logic        b;
        st = tx_state[lane];
        for (int i = 0; i < NB_PAYLOAD; i++)
        begin
            b = plain[i] ^ st[38] ^ st[57];
            scr[i] = b;
            st = {st[56:0], b};
        end
        tx_state[lane] = st;
    endtask

    task automatic compare_rx_block(input int lane, input pcs_rx_pkg::rx_block_t got,
                                    input pcs_rx_pkg::rx_block_t exp);
        // payload and header only matter for a valid block
        if (got.valid !== exp.valid || (exp.valid && got !== exp))
        begin
            stop_with_error($sformatf("[ERROR] o_rx_blocks[%0d] got %h expected %h",
                                      lane, got, exp));
        end
    endtask

    task automatic compare_reg(input string name, input logic [NB_DATA-1:0] got,
                               input logic [NB_DATA-1:0] exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic expect_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
        begin
            stop_with_error($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
        end
    endtask

    // drive at posedge and check the previous cycle's output at negedge
    task automatic clock_cycle();
        @(posedge i_clock);
        rx_in   <= next_rx;
        apb_req <= next_apb;
        @(negedge i_clock);
        for (int n = 0; n < N_LANES; n++)
        begin
            if (pend_chk[n])
            begin
                compare_rx_block(n, rx_out[n], pend_exp[n]);
            end
        end
        pend_exp = next_exp;
        pend_chk = next_chk;
    endtask

    task automatic idle_lanes();
        next_rx = '0;
        for (int n = 0; n < N_LANES; n++)
        begin
            next_exp[n] = '0;
        end
        next_chk = ALL_LANES;
    endtask

    // bad_lane gets invalid headers on its first bad_count blocks
    task automatic send_blocks(input int count, input int bad_lane, input int bad_count,
                               input logic [N_LANES-1:0] lock_exp,
                               input logic [N_LANES-1:0] chk);
        logic [NB_PAYLOAD-1:0] plain;
        logic [NB_PAYLOAD-1:0] scr;
        logic [NB_SH-1:0]      hdr;
        logic [31:0]           r;
        for (int b = 0; b < count; b++)
        begin
            for (int n = 0; n < N_LANES; n++)
            begin
                plain[63:32] = xorshift32();
                plain[31:0]  = xorshift32();
                r = xorshift32();
                scramble_payload(n, plain, scr);
                if (n == bad_lane && b < bad_count)
                begin
                    hdr = r[0] ? 2'b11 : 2'b00;
                end
                else
                begin
                    hdr = r[0] ? 2'b10 : 2'b01;
                end
                next_rx[n]  = '{valid: 1'b1, header: hdr, payload: scr};
                next_exp[n] = '{valid: lock_exp[n], header: hdr,
                                payload: descramble_on ? plain : scr};
            end
            next_chk = chk;
            clock_cycle();
            total_blocks++;
        end
        idle_lanes();
    endtask

    task automatic bus_transfer(input logic write, input logic [NB_ADDR-1:0] addr,
                                input logic [NB_DATA-1:0] wdata,
                                output logic [NB_DATA-1:0] rdata, output logic err);
        int waits;
        idle_lanes();
        next_apb = '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
        clock_cycle();
        next_apb.penable = 1'b1;
        clock_cycle();
        waits = 0;
        while (!apb_rsp.pready)
        begin
            waits++;
            if (waits > APB_TIMEOUT)
            begin
                stop_with_error("APB slave never raised pready");
            end
            clock_cycle();
        end
        rdata = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        next_apb = '0;
    endtask

    task automatic apb_read(input logic [NB_ADDR-1:0] addr, output logic [NB_DATA-1:0] data,
                            output logic err);
        bus_transfer(1'b0, addr, '0, data, err);
    endtask

    task automatic apb_write(input logic [NB_ADDR-1:0] addr, input logic [NB_DATA-1:0] data,
                             output logic err);
        logic [NB_DATA-1:0] unused;
        bus_transfer(1'b1, addr, data, unused, err);
    endtask

    task automatic check_read(input logic [NB_ADDR-1:0] addr, input logic [NB_DATA-1:0] exp);
        logic [NB_DATA-1:0] data;
        logic               err;
        apb_read(addr, data, err);
        compare_reg($sformatf("prdata at %h", addr), data, exp);
        expect_flag($sformatf("pslverr at %h", addr), err, 1'b0);
    endtask

    task automatic ctrl_write(input logic [NB_DATA-1:0] data);
        logic err;
        apb_write(pcs_rx_pkg::REG_CTRL, data, err);
        expect_flag("pslverr on REG_CTRL write", err, 1'b0);
    endtask

    task automatic reset_values();
        logic [NB_DATA-1:0] data;
        logic               err;
        check_read(pcs_rx_pkg::REG_LOCK, '0);
        check_read(pcs_rx_pkg::REG_HI_BER, '0);
        for (int n = 0; n < N_LANES; n++)
        begin
            check_read(err_addr(n), '0);
        end
        check_read(pcs_rx_pkg::REG_CTRL, 32'h1);
        apb_read(8'h40, data, err);
        expect_flag("pslverr on read at 40", err, 1'b1);
        apb_write(pcs_rx_pkg::REG_LOCK, 32'h1, err);
        expect_flag("pslverr on write to REG_LOCK", err, 1'b1);
    endtask

    task automatic lock_and_descramble();
        // no lane is locked while the first LOCK_COUNT blocks go in
        send_blocks(LOCK_COUNT, -1, 0, '0, ALL_LANES);
        check_read(pcs_rx_pkg::REG_LOCK, lane_word(ALL_LANES));
        send_blocks(32, -1, 0, ALL_LANES, ALL_LANES);
    endtask

    task automatic descrambler_bypass();
        ctrl_write(32'h0);
        descramble_on = 1'b0;
        send_blocks(16, -1, 0, ALL_LANES, ALL_LANES);
        check_read(pcs_rx_pkg::REG_CTRL, 32'h0);
        ctrl_write(32'h1);
        descramble_on = 1'b1;
        send_blocks(16, -1, 0, ALL_LANES, ALL_LANES);
    endtask

    task automatic error_counter_clear();
        localparam int K = 5;
        send_blocks(K + 8, 2, K, ALL_LANES, ALL_LANES);
        for (int n = 0; n < N_LANES; n++)
        begin
            check_read(err_addr(n), (n == 2) ? NB_DATA'(K) : '0);
        end
        check_read(err_addr(2), '0);
        check_read(pcs_rx_pkg::REG_LOCK, lane_word(ALL_LANES));
    endtask

    task automatic loss_of_lock();
        int pad;
        // lock windows start on the block after lock was reached
        pad = (UNLOCK_WINDOW - ((total_blocks - LOCK_COUNT) % UNLOCK_WINDOW)) % UNLOCK_WINDOW;
        send_blocks(pad, -1, 0, ALL_LANES, ALL_LANES);
        send_blocks(UNLOCK_LIMIT, 1, UNLOCK_LIMIT, ALL_LANES, ALL_LANES);
        check_read(pcs_rx_pkg::REG_LOCK, lane_word(4'b1101));
        send_blocks(8, -1, 0, 4'b1101, ALL_LANES);
    endtask

    task automatic high_ber_flag();
        int pad;
        int window_start;
        // lanes 1 and 3 may relock at any point here
        pad = (BER_WINDOW - (total_blocks % BER_WINDOW)) % BER_WINDOW;
        send_blocks(pad, -1, 0, ALL_LANES, 4'b0101);
        window_start = total_blocks;
        send_blocks(HI_BER_COUNT + 4, 3, HI_BER_COUNT, ALL_LANES, 4'b0101);
        check_read(pcs_rx_pkg::REG_HI_BER, lane_word(4'b1000));
        // rest of this window, then one clean window
        send_blocks(window_start + 2 * BER_WINDOW - total_blocks, -1, 0, ALL_LANES, 4'b0101);
        check_read(pcs_rx_pkg::REG_HI_BER, lane_word(4'b1000));
        check_read(pcs_rx_pkg::REG_HI_BER, '0);
    endtask

    initial
    begin
        i_reset       = 1'b1;
        rx_in         = '0;
        apb_req       = '0;
        next_apb      = '0;
        pend_chk      = '0;
        rng_state     = 32'hef3c_836c;
        descramble_on = 1'b1;
        total_blocks  = 0;
        for (int n = 0; n < N_LANES; n++)
        begin
            tx_state[n] = '0;
            pend_exp[n] = '0;
        end
        idle_lanes();
        repeat (4) @(posedge i_clock);
        i_reset <= 1'b0;

        reset_values();
        lock_and_descramble();
        descrambler_bypass();
        error_counter_clear();
        loss_of_lock();
        high_ber_flag();
        clock_cycle();

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire
